/* flist.f */
+incdir+tb
src/uart_axil_pkg.sv
src/uart_fifo_if.sv
src/uart_sync_fifo.sv
src/axil_uart_regs.sv
src/uart_tx_serial.sv
src/uart_rx_serial.sv
src/axil_uart.sv
tb/tb_axil_uart.sv

/* tb/tb_axil_uart_tasks.svh */
`ifndef TB_AXIL_UART_TASKS_SVH
`define TB_AXIL_UART_TASKS_SVH

// byte address of a word register
function automatic axil_addr_t reg_addr(input reg_sel_t sel);
	return {sel, 2'b00};
endfunction

// lanes with a strobe bit take the new byte and the others keep the old one
function automatic axil_data_t merge_bytes(input axil_data_t old_word,
	input axil_data_t new_word, input logic [3:0] strb);
	axil_data_t lane_mask;
	lane_mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
	return (old_word & ~lane_mask) | (new_word & lane_mask);
endfunction

////////////////////
// bus accesses
////////////////////

// readies are looked at on the falling edge, where every input has settled
task automatic write_reg(input axil_addr_t addr, input axil_data_t data,
	input logic [3:0] strb);
	int waited;
	int delay;
	@(posedge S_AXI_ACLK);
	#1;
	s_axi_awvalid = 1'b1;
	s_axi_awaddr  = addr;
	s_axi_wvalid  = 1'b1;
	s_axi_wdata   = data;
	s_axi_wstrb   = strb;
	waited = 0;
	@(negedge S_AXI_ACLK);
	while (!s_axi_awready && (waited < HS_TIMEOUT))
	begin
		waited++;
		@(negedge S_AXI_ACLK);
	end
	@(posedge S_AXI_ACLK);
	#1;
	s_axi_awvalid = 1'b0;
	s_axi_wvalid  = 1'b0;
	if (waited >= HS_TIMEOUT)
	begin
		$display("write to address %h was never accepted by the slave", addr);
		timeouts++;
		return;
	end
	waited = 0;
	while (!s_axi_bvalid && (waited < HS_TIMEOUT))
	begin
		waited++;
		@(negedge S_AXI_ACLK);
	end
	if (!s_axi_bvalid)
	begin
		$display("write to address %h never got a response", addr);
		timeouts++;
		return;
	end
	// the response has to wait a random number of cycles for the master
	delay = $urandom_range(3, 0);
	repeat (delay) @(posedge S_AXI_ACLK);
	@(posedge S_AXI_ACLK);
	#1;
	s_axi_bready = 1'b1;
	@(posedge S_AXI_ACLK);
	#1;
	s_axi_bready = 1'b0;
endtask

task automatic read_reg(input axil_addr_t addr, output axil_data_t data);
	int waited;
	int delay;
	data = 'x;
	@(posedge S_AXI_ACLK);
	#1;
	s_axi_arvalid = 1'b1;
	s_axi_araddr  = addr;
	waited = 0;
	@(negedge S_AXI_ACLK);
	while (!s_axi_arready && (waited < HS_TIMEOUT))
	begin
		waited++;
		@(negedge S_AXI_ACLK);
	end
	@(posedge S_AXI_ACLK);
	#1;
	s_axi_arvalid = 1'b0;
	if (waited >= HS_TIMEOUT)
	begin
		$display("read of address %h was never accepted by the slave", addr);
		timeouts++;
		return;
	end
	waited = 0;
	while (!s_axi_rvalid && (waited < HS_TIMEOUT))
	begin
		waited++;
		@(negedge S_AXI_ACLK);
	end
	if (!s_axi_rvalid)
	begin
		$display("read of address %h never returned data", addr);
		timeouts++;
		return;
	end
	delay = $urandom_range(3, 0);
	repeat (delay) @(posedge S_AXI_ACLK);
	@(posedge S_AXI_ACLK);
	#1;
	s_axi_rready = 1'b1;
	// the word is taken just before the handshake edge
	@(negedge S_AXI_ACLK);
	data = s_axi_rdata;
	@(posedge S_AXI_ACLK);
	#1;
	s_axi_rready = 1'b0;
endtask

// arms the data check for one read so that the assertion compares the masked word
task automatic expect_read(input axil_addr_t addr, input axil_data_t mask,
	input axil_data_t value);
	axil_data_t got;
	exp_mask = mask;
	exp_val  = value & mask;
	chk_val  = 1'b1;
	read_reg(addr, got);
	chk_val  = 1'b0;
endtask

// keeps reading a register until the masked word matches
task automatic wait_for_reg(input axil_addr_t addr, input axil_data_t mask,
	input axil_data_t value, input string what);
	axil_data_t got;
	int tries;
	// a byte written and not yet read back sits in one FIFO or on the line
	tx_fill_max = n_written - n_read;
	chk_fill = (addr[3:2] == REG_FIFO);
	tries = 0;
	read_reg(addr, got);
	while (((got & mask) != value) && (tries < POLL_TRIES))
	begin
		tries++;
		read_reg(addr, got);
	end
	chk_fill = 1'b0;
	if ((got & mask) != value)
	begin
		$display("timed out waiting for the %s", what);
		timeouts++;
	end
endtask

`endif

/* tb/tb_axil_uart.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axil_uart;
	import uart_axil_pkg::*;

	// handshake waits count cycles and register polls count reads
	localparam int HS_TIMEOUT = 100;
	localparam int POLL_TRIES = 200;

	logic       S_AXI_ACLK;
	logic       S_AXI_ARESETN;
	logic       s_axi_awvalid;
	logic       s_axi_awready;
	axil_addr_t s_axi_awaddr;
	logic       s_axi_wvalid;
	logic       s_axi_wready;
	axil_data_t s_axi_wdata;
	logic [3:0] s_axi_wstrb;
	logic       s_axi_bvalid;
	logic       s_axi_bready;
	logic [1:0] s_axi_bresp;
	logic       s_axi_arvalid;
	logic       s_axi_arready;
	axil_addr_t s_axi_araddr;
	logic       s_axi_rvalid;
	logic       s_axi_rready;
	axil_data_t s_axi_rdata;
	logic [1:0] s_axi_rresp;
	// transmit output wired straight back into the receiver
	logic       uart_line;

	int         value_errs;
	int         timeouts;
	int         n_written;
	int         n_read;
	int         tx_fill_max;
	int         k;
	logic       chk_val;
	logic       chk_fill;
	axil_data_t exp_mask;
	axil_data_t exp_val;
	axil_data_t setup_model;
	axil_data_t wr_word;
	uart_byte_t want_b;
	uart_byte_t sent_q[$];

	axil_uart #(.LGFLEN(2), .INITIAL_SETUP(24'd8)) dut0 (
		.S_AXI_ACLK     (S_AXI_ACLK),
		.S_AXI_ARESETN  (S_AXI_ARESETN),
		.i_s_axi_awvalid(s_axi_awvalid),
		.o_s_axi_awready(s_axi_awready),
		.i_s_axi_awaddr (s_axi_awaddr),
		.i_s_axi_wvalid (s_axi_wvalid),
		.o_s_axi_wready (s_axi_wready),
		.i_s_axi_wdata  (s_axi_wdata),
		.i_s_axi_wstrb  (s_axi_wstrb),
		.o_s_axi_bvalid (s_axi_bvalid),
		.i_s_axi_bready (s_axi_bready),
		.o_s_axi_bresp  (s_axi_bresp),
		.i_s_axi_arvalid(s_axi_arvalid),
		.o_s_axi_arready(s_axi_arready),
		.i_s_axi_araddr (s_axi_araddr),
		.o_s_axi_rvalid (s_axi_rvalid),
		.i_s_axi_rready (s_axi_rready),
		.o_s_axi_rdata  (s_axi_rdata),
		.o_s_axi_rresp  (s_axi_rresp),
		.i_uart_rx      (uart_line),
		.o_uart_tx      (uart_line)
	);

	`include "tb_axil_uart_tasks.svh"

	always #2 S_AXI_ACLK = ~S_AXI_ACLK;

	////////////////////
	// checks
	////////////////////

	// one cycle out of reset every channel is quiet and the line idles high
	a_reset_state: assert property (@(posedge S_AXI_ACLK) !S_AXI_ARESETN |=>
		uart_line && !s_axi_awready && !s_axi_wready && !s_axi_arready &&
		!s_axi_rvalid && !s_axi_bvalid)
	else
	begin
		$display("ERR %0t: bus or serial line not quiet after reset", $time);
		value_errs++;
	end

	// address and data of a write are accepted in the same cycle
	a_write_ready_pair: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_awready == s_axi_wready)
	else
	begin
		$display("ERR %0t: AWREADY %b and WREADY %b differ", $time, s_axi_awready,
			s_axi_wready);
		value_errs++;
	end

	// every response is OKAY
	a_resp_okay: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(!s_axi_bvalid || (s_axi_bresp == 2'b00)) && (!s_axi_rvalid || (s_axi_rresp == 2'b00)))
	else
	begin
		$display("ERR %0t: response BRESP %b RRESP %b is not OKAY", $time, s_axi_bresp,
			s_axi_rresp);
		value_errs++;
	end

	a_write_resp: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_awvalid && s_axi_awready |=> s_axi_bvalid)
	else
	begin
		$display("ERR %0t: BVALID not one edge after the write handshake", $time);
		value_errs++;
	end

	a_read_latency: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_arvalid && s_axi_arready |=> !s_axi_rvalid ##1 s_axi_rvalid)
	else
	begin
		$display("ERR %0t: RVALID not two edges after the read handshake", $time);
		value_errs++;
	end

	a_bvalid_stable: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
	else
	begin
		$display("ERR %0t: BVALID dropped before BREADY", $time);
		value_errs++;
	end

	a_rdata_stable: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata))
	else
	begin
		$display("ERR %0t: read response changed while waiting for RREADY", $time);
		value_errs++;
	end

	a_read_value: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_rvalid && s_axi_rready && chk_val |-> ((s_axi_rdata & exp_mask) == exp_val))
	else
	begin
		$display("ERR %0t: read %h under mask %h, expected %h", $time, s_axi_rdata,
			exp_mask, exp_val);
		value_errs++;
	end

	// bytes already received into the rx FIFO no longer count as owed to the tx FIFO
	a_tx_fill: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_rvalid && s_axi_rready && chk_fill |->
		((int'(s_axi_rdata[23:16]) + int'(s_axi_rdata[7:0])) <= tx_fill_max))
	else
	begin
		$display("ERR %0t: tx fill %0d with rx fill %0d above the %0d bytes still owed",
			$time, s_axi_rdata[23:16], s_axi_rdata[7:0], tx_fill_max);
		value_errs++;
	end

	////////////////////
	// stimulus
	////////////////////

	initial
	begin
		void'($urandom(32'h6d80));
		S_AXI_ACLK    = 1'b0;
		S_AXI_ARESETN = 1'b0;
		s_axi_awvalid = 1'b0;
		s_axi_awaddr  = '0;
		s_axi_wvalid  = 1'b0;
		s_axi_wdata   = '0;
		s_axi_wstrb   = '0;
		s_axi_bready  = 1'b0;
		s_axi_arvalid = 1'b0;
		s_axi_araddr  = '0;
		s_axi_rready  = 1'b0;
		value_errs = 0;
		timeouts   = 0;
		n_written  = 0;
		n_read     = 0;
		tx_fill_max = 0;
		chk_val  = 1'b0;
		chk_fill = 1'b0;
		exp_mask = '0;
		exp_val  = '0;
		repeat (2) @(posedge S_AXI_ACLK);
		#1;
		S_AXI_ARESETN = 1'b1;

		// reset values of the divisor and both fill levels
		expect_read(reg_addr(REG_SETUP), 32'hffff_ffff, 32'd8);
		expect_read(reg_addr(REG_FIFO), 32'hffff_ffff, 32'd0);

		// the top byte of the setup word always reads zero under partial strobes
		setup_model = 32'd8;
		wr_word = $urandom();
		write_reg(reg_addr(REG_SETUP), wr_word, 4'b1010);
		setup_model = merge_bytes(setup_model, wr_word, 4'b1010) & 32'h00ff_ffff;
		expect_read(reg_addr(REG_SETUP), 32'hffff_ffff, setup_model);
		wr_word = $urandom();
		write_reg(reg_addr(REG_SETUP), wr_word, 4'b0100);
		setup_model = merge_bytes(setup_model, wr_word, 4'b0100) & 32'h00ff_ffff;
		expect_read(reg_addr(REG_SETUP), 32'hffff_ffff, setup_model);
		// back to eight clocks per bit for the serial traffic
		write_reg(reg_addr(REG_SETUP), 32'd8, 4'b0111);
		expect_read(reg_addr(REG_SETUP), 32'hffff_ffff, 32'd8);

		// three bytes go around the loop and are read back in order
		for (k = 0; k < 3; k++)
		begin
			want_b = uart_byte_t'($urandom());
			sent_q.push_back(want_b);
			write_reg(reg_addr(REG_TX), {24'h0, want_b}, 4'b0001);
			n_written++;
		end
		expect_read(reg_addr(REG_TX), 32'h100, 32'h100);
		wait_for_reg(reg_addr(REG_FIFO), 32'hff, 32'd3, "three looped bytes");
		for (k = 0; k < 3; k++)
		begin
			want_b = sent_q.pop_front();
			expect_read(reg_addr(REG_RX), 32'h1ff, {24'h0, want_b});
			n_read++;
		end
		expect_read(reg_addr(REG_RX), 32'h100, 32'h100);

		// six bytes overrun the four entry receive FIFO and the last two are lost
		for (k = 0; k < 6; k++)
		begin
			if (k == 3)
				wait_for_reg(reg_addr(REG_FIFO), 32'h00ff_0000, 32'd0,
					"transmit FIFO to drain");
			want_b = uart_byte_t'($urandom());
			sent_q.push_back(want_b);
			write_reg(reg_addr(REG_TX), {24'h0, want_b}, 4'b0001);
			n_written++;
		end
		wait_for_reg(reg_addr(REG_TX), 32'h100, 32'h0, "transmitter to go idle");
		for (k = 0; k < 4; k++)
		begin
			want_b = sent_q.pop_front();
			expect_read(reg_addr(REG_RX), 32'h11ff, {19'h0, 1'b1, 4'h0, want_b});
			n_read++;
		end
		expect_read(reg_addr(REG_RX), 32'h1100, 32'h1100);
		// any write to the receive register clears the sticky overflow
		write_reg(reg_addr(REG_RX), 32'h0, 4'b1111);
		expect_read(reg_addr(REG_RX), 32'h1100, 32'h0100);

		$display("value errors: %0d, timeouts: %0d", value_errs, timeouts);
		if ((value_errs == 0) && (timeouts == 0))
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* src/axil_uart.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_uart #(
	parameter int                       LGFLEN        = 2,
	parameter uart_axil_pkg::baud_div_t INITIAL_SETUP = 24'd8
) (
	input  logic                      S_AXI_ACLK,
	input  logic                      S_AXI_ARESETN,
	input  logic                      i_s_axi_awvalid,
	output logic                      o_s_axi_awready,
	input  uart_axil_pkg::axil_addr_t i_s_axi_awaddr,
	input  logic                      i_s_axi_wvalid,
	output logic                      o_s_axi_wready,
	input  uart_axil_pkg::axil_data_t i_s_axi_wdata,
	input  logic [3:0]                i_s_axi_wstrb,
	output logic                      o_s_axi_bvalid,
	input  logic                      i_s_axi_bready,
	output logic [1:0]                o_s_axi_bresp,
	input  logic                      i_s_axi_arvalid,
	output logic                      o_s_axi_arready,
	input  uart_axil_pkg::axil_addr_t i_s_axi_araddr,
	output logic                      o_s_axi_rvalid,
	input  logic                      i_s_axi_rready,
	output uart_axil_pkg::axil_data_t o_s_axi_rdata,
	output logic [1:0]                o_s_axi_rresp,
	input  logic                      i_uart_rx,
	output logic                      o_uart_tx
);
	import uart_axil_pkg::*;

	baud_div_t baud_div;
	logic      tx_busy;
	logic      rx_overflow_set;

	// register slave pushes into tx and pops from rx
	uart_fifo_if #(.LGFLEN(LGFLEN)) tx_fifo_if ();
	uart_fifo_if #(.LGFLEN(LGFLEN)) rx_fifo_if ();

	axil_uart_regs #(
		.INITIAL_SETUP(INITIAL_SETUP)
	) u_regs (
		.S_AXI_ACLK       (S_AXI_ACLK),
		.S_AXI_ARESETN    (S_AXI_ARESETN),
		.i_s_axi_awvalid  (i_s_axi_awvalid),
		.o_s_axi_awready  (o_s_axi_awready),
		.i_s_axi_awaddr   (i_s_axi_awaddr),
		.i_s_axi_wvalid   (i_s_axi_wvalid),
		.o_s_axi_wready   (o_s_axi_wready),
		.i_s_axi_wdata    (i_s_axi_wdata),
		.i_s_axi_wstrb    (i_s_axi_wstrb),
		.o_s_axi_bvalid   (o_s_axi_bvalid),
		.i_s_axi_bready   (i_s_axi_bready),
		.o_s_axi_bresp    (o_s_axi_bresp),
		.i_s_axi_arvalid  (i_s_axi_arvalid),
		.o_s_axi_arready  (o_s_axi_arready),
		.i_s_axi_araddr   (i_s_axi_araddr),
		.o_s_axi_rvalid   (o_s_axi_rvalid),
		.i_s_axi_rready   (i_s_axi_rready),
		.o_s_axi_rdata    (o_s_axi_rdata),
		.o_s_axi_rresp    (o_s_axi_rresp),
		.i_uart_rx        (i_uart_rx),
		.i_uart_tx_line   (o_uart_tx),
		.i_tx_busy        (tx_busy),
		.i_rx_overflow_set(rx_overflow_set),
		.o_baud_div       (baud_div),
		.tx_fifo          (tx_fifo_if.producer),
		.rx_fifo          (rx_fifo_if.consumer)
	);

	uart_sync_fifo #(.LGFLEN(LGFLEN)) u_tx_fifo (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.f_if         (tx_fifo_if.fifo)
	);

	uart_sync_fifo #(.LGFLEN(LGFLEN)) u_rx_fifo (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.f_if         (rx_fifo_if.fifo)
	);

	uart_tx_serial u_tx (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_baud_div   (baud_div),
		.tx_fifo      (tx_fifo_if.consumer),
		.o_uart_tx    (o_uart_tx),
		.o_busy       (tx_busy)
	);

	uart_rx_serial u_rx (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_uart_rx     (i_uart_rx),
		.i_baud_div    (baud_div),
		.rx_fifo       (rx_fifo_if.producer),
		.o_overflow_set(rx_overflow_set)
	);

endmodule

`default_nettype wire

/* src/uart_rx_serial.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx_serial (
	input  logic                     S_AXI_ACLK,
	input  logic                     S_AXI_ARESETN,
	input  logic                     i_uart_rx,
	input  uart_axil_pkg::baud_div_t i_baud_div,
	uart_fifo_if.producer            rx_fifo,
	output logic                     o_overflow_set
);
	import uart_axil_pkg::*;

	rx_state_t  state;
	baud_div_t  cnt;
	logic [2:0] bit_idx;
	uart_byte_t shift;
	logic       rx_meta;
	logic       rx_sync;
	logic       rx_prev;
	logic       bit_done;
	logic       fifo_full;
	logic       stop_ok;

	// the line is asynchronous, two flops bring it into the clock domain
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end
		else
		begin
			rx_meta <= i_uart_rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	assign bit_done = (cnt == '0);

	// fill never exceeds the depth, so its top bit alone marks a full FIFO
	assign fifo_full = rx_fifo.fill[$bits(rx_fifo.fill)-1];

	// stop bit sampled high at its middle completes the frame
	assign stop_ok           = (state == RX_STOP) && bit_done && rx_sync;
	assign rx_fifo.push      = stop_ok;
	assign rx_fifo.push_data = shift;
	assign o_overflow_set    = stop_ok && fifo_full;

	// LSB arrives first and enters from the top
	always_ff @(posedge S_AXI_ACLK)
	begin
		if ((state == RX_DATA) && bit_done)
			shift <= {rx_sync, shift[7:1]};
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			state   <= RX_IDLE;
			cnt     <= '0;
			bit_idx <= '0;
		end
		else
		begin
			case (state)
				RX_IDLE:
				begin
					// falling edge starts a frame, wait half a bit to reach its middle
					if (rx_prev && !rx_sync)
					begin
						cnt   <= i_baud_div >> 1;
						state <= RX_START;
					end
				end
				RX_START:
				begin
					if (bit_done)
					begin
						// a start bit that is already high again was only a glitch
						if (!rx_sync)
						begin
							cnt     <= i_baud_div - 1'b1;
							bit_idx <= '0;
							state   <= RX_DATA;
						end
						else
							state <= RX_IDLE;
					end
					else
						cnt <= cnt - 1'b1;
				end
				RX_DATA:
				begin
					if (bit_done)
					begin
						cnt     <= i_baud_div - 1'b1;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end
					else
						cnt <= cnt - 1'b1;
				end
				default:
				begin
					// a framing error drops the byte and waits for the next edge
					if (bit_done)
						state <= RX_IDLE;
					else
						cnt <= cnt - 1'b1;
				end
			endcase
		end
	end

	a_push_at_stop: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		rx_fifo.push |-> (state == RX_STOP) ##1 (state == RX_IDLE));

endmodule

`default_nettype wire

/* src/uart_tx_serial.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx_serial (
	input  logic                     S_AXI_ACLK,
	input  logic                     S_AXI_ARESETN,
	input  uart_axil_pkg::baud_div_t i_baud_div,
	uart_fifo_if.consumer            tx_fifo,
	output logic                     o_uart_tx,
	output logic                     o_busy
);
	import uart_axil_pkg::*;

	tx_state_t  state;
	baud_div_t  cnt;
	logic [2:0] bit_idx;
	uart_byte_t shift;
	logic       bit_done;

	assign bit_done = (cnt == '0);

	// a new byte is taken whenever the line is idle and one is waiting
	assign tx_fifo.pop = (state == TX_IDLE) && tx_fifo.empty_n;
	assign o_busy      = (state != TX_IDLE);

	// data goes out LSB first, so the register shifts right after each bit
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (tx_fifo.pop)
			shift <= tx_fifo.pop_data;
		else if (bit_done && ((state == TX_START) || (state == TX_DATA)))
			shift <= shift >> 1;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			state     <= TX_IDLE;
			o_uart_tx <= 1'b1;
			cnt       <= '0;
			bit_idx   <= '0;
		end
		else
		begin
			case (state)
				TX_IDLE:
				begin
					if (tx_fifo.pop)
					begin
						o_uart_tx <= 1'b0;
						cnt       <= i_baud_div - 1'b1;
						state     <= TX_START;
					end
				end
				TX_START:
				begin
					if (bit_done)
					begin
						o_uart_tx <= shift[0];
						cnt       <= i_baud_div - 1'b1;
						bit_idx   <= '0;
						state     <= TX_DATA;
					end
					else
						cnt <= cnt - 1'b1;
				end
				TX_DATA:
				begin
					if (bit_done)
					begin
						cnt <= i_baud_div - 1'b1;
						// after the eighth bit the line goes high for the stop bit
						if (bit_idx == 3'd7)
						begin
							o_uart_tx <= 1'b1;
							state     <= TX_STOP;
						end
						else
						begin
							o_uart_tx <= shift[0];
							bit_idx   <= bit_idx + 1'b1;
						end
					end
					else
						cnt <= cnt - 1'b1;
				end
				default:
				begin
					if (bit_done)
						state <= TX_IDLE;
					else
						cnt <= cnt - 1'b1;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/axil_uart_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_uart_regs #(
	parameter uart_axil_pkg::baud_div_t INITIAL_SETUP = 24'd8
) (
	input  logic                      S_AXI_ACLK,
	input  logic                      S_AXI_ARESETN,
	input  logic                      i_s_axi_awvalid,
	output logic                      o_s_axi_awready,
	input  uart_axil_pkg::axil_addr_t i_s_axi_awaddr,
	input  logic                      i_s_axi_wvalid,
	output logic                      o_s_axi_wready,
	input  uart_axil_pkg::axil_data_t i_s_axi_wdata,
	input  logic [3:0]                i_s_axi_wstrb,
	output logic                      o_s_axi_bvalid,
	input  logic                      i_s_axi_bready,
	output logic [1:0]                o_s_axi_bresp,
	input  logic                      i_s_axi_arvalid,
	output logic                      o_s_axi_arready,
	input  uart_axil_pkg::axil_addr_t i_s_axi_araddr,
	output logic                      o_s_axi_rvalid,
	input  logic                      i_s_axi_rready,
	output uart_axil_pkg::axil_data_t o_s_axi_rdata,
	output logic [1:0]                o_s_axi_rresp,
	input  logic                      i_uart_rx,
	input  logic                      i_uart_tx_line,
	input  logic                      i_tx_busy,
	input  logic                      i_rx_overflow_set,
	output uart_axil_pkg::baud_div_t  o_baud_div,
	uart_fifo_if.producer             tx_fifo,
	uart_fifo_if.consumer             rx_fifo
);
	import uart_axil_pkg::*;

	logic       axil_live;
	logic       axil_write_ready;
	logic       axil_read_ready;
	reg_sel_t   wr_sel;
	reg_sel_t   rd_sel;
	reg_sel_t   r_rd_sel;
	logic       r_preread;
	baud_div_t  r_setup;
	axil_data_t new_setup;
	logic       r_overflow;
	axil_data_t rx_word;
	axil_data_t r_rx_word;
	axil_data_t fifo_word;
	axil_data_t tx_word;
	uart_byte_t tx_fill_b;
	uart_byte_t rx_fill_b;

	// merge a write word into the prior contents, one byte lane per strobe bit
	function automatic axil_data_t apply_wstrb(input axil_data_t prior,
		input axil_data_t fresh, input logic [3:0] strb);
		axil_data_t merged;
		merged = prior;
		for (int k = 0; k < 4; k++)
		begin
			if (strb[k])
				merged[k*8 +: 8] = fresh[k*8 +: 8];
		end
		return merged;
	endfunction

	// holds every ready low for the first cycle out of reset
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			axil_live <= 1'b0;
		else
			axil_live <= 1'b1;
	end

	////////////////////
	// write channel
	////////////////////

	// address and data are taken together, one write outstanding at a time
	assign axil_write_ready = axil_live && i_s_axi_awvalid && i_s_axi_wvalid && !o_s_axi_bvalid;
	assign o_s_axi_awready  = axil_write_ready;
	assign o_s_axi_wready   = axil_write_ready;
	assign o_s_axi_bresp    = AXI_RESP_OKAY;
	assign wr_sel           = i_s_axi_awaddr[3:2];

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_s_axi_bvalid <= 1'b0;
		else if (axil_write_ready)
			o_s_axi_bvalid <= 1'b1;
		else if (i_s_axi_bready)
			o_s_axi_bvalid <= 1'b0;
	end

	// only the low three byte lanes land in the divisor
	assign new_setup = apply_wstrb({8'h00, r_setup}, i_s_axi_wdata, i_s_axi_wstrb);

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			r_setup <= INITIAL_SETUP;
		else if (axil_write_ready && (wr_sel == REG_SETUP))
			r_setup <= new_setup[23:0];
	end

	assign o_baud_div = r_setup;

	// the FIFO takes the byte on the same edge that raises BVALID
	assign tx_fifo.push      = axil_write_ready && (wr_sel == REG_TX) && i_s_axi_wstrb[0];
	assign tx_fifo.push_data = i_s_axi_wdata[7:0];

	// a lost receive byte stays flagged until software writes REG_RX
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			r_overflow <= 1'b0;
		else if (i_rx_overflow_set)
			r_overflow <= 1'b1;
		else if (axil_write_ready && (wr_sel == REG_RX))
			r_overflow <= 1'b0;
	end

	////////////////////
	// read channel
	////////////////////

	assign o_s_axi_arready = axil_live && !o_s_axi_rvalid && !r_preread;
	assign axil_read_ready = i_s_axi_arvalid && o_s_axi_arready;
	assign rd_sel          = i_s_axi_araddr[3:2];
	assign o_s_axi_rresp   = AXI_RESP_OKAY;

	// popping at the handshake is safe since the head is captured on that same edge
	assign rx_fifo.pop = axil_read_ready && (rd_sel == REG_RX) && rx_fifo.empty_n;

	// bit 12 overflow, bit 8 empty, low byte is the head entry or zero
	assign rx_word = {19'h0, r_overflow, 3'h0, !rx_fifo.empty_n,
		rx_fifo.empty_n ? rx_fifo.pop_data : 8'h00};

	assign tx_fill_b = uart_byte_t'(tx_fifo.fill);
	assign rx_fill_b = uart_byte_t'(rx_fifo.fill);
	assign fifo_word = {8'h00, tx_fill_b, 8'h00, rx_fill_b};

	// line levels and busy have no side effects, so reading REG_TX is free
	assign tx_word = {21'h0, i_uart_rx, i_uart_tx_line, i_tx_busy | tx_fifo.empty_n, 8'h00};

	// first stage of the two-cycle read
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			r_preread <= 1'b0;
		else if (axil_read_ready)
			r_preread <= 1'b1;
		else if (!o_s_axi_rvalid || i_s_axi_rready)
			r_preread <= 1'b0;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (axil_read_ready)
		begin
			r_rd_sel  <= rd_sel;
			r_rx_word <= rx_word;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_s_axi_rvalid <= 1'b0;
		else if (r_preread)
			o_s_axi_rvalid <= 1'b1;
		else if (i_s_axi_rready)
			o_s_axi_rvalid <= 1'b0;
	end

	// the word is frozen while a response waits for RREADY
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!o_s_axi_rvalid || i_s_axi_rready)
		begin
			case (r_rd_sel)
				REG_SETUP: o_s_axi_rdata <= {8'h00, r_setup};
				REG_FIFO:  o_s_axi_rdata <= fifo_word;
				REG_RX:    o_s_axi_rdata <= r_rx_word;
				default:   o_s_axi_rdata <= tx_word;
			endcase
		end
	end

	a_bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		o_s_axi_bvalid && !i_s_axi_bready |=> o_s_axi_bvalid);

	a_single_read: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		!(o_s_axi_arready && o_s_axi_rvalid));

endmodule

`default_nettype wire

/* src/uart_sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_sync_fifo #(
	parameter int LGFLEN = 2
) (
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	uart_fifo_if.fifo f_if
);
	import uart_axil_pkg::*;

	localparam int DEPTH = 1 << LGFLEN;

	uart_byte_t        mem [DEPTH];
	logic [LGFLEN-1:0] wr_ptr;
	logic [LGFLEN-1:0] rd_ptr;
	logic [LGFLEN:0]   fill;
	logic              full;
	logic              do_push;
	logic              do_pop;

	assign full = (fill == (LGFLEN+1)'(DEPTH));

	// a push while full and a pop while empty are both ignored
	assign do_push = f_if.push && !full;
	assign do_pop  = f_if.pop && (fill != '0);

	// storage, written at the write pointer
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (do_push)
			mem[wr_ptr] <= f_if.push_data;
	end

	// pointers wrap naturally at the power of two depth
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			// simultaneous push and pop leave the level unchanged
			if (do_push && !do_pop)
				fill <= fill + 1'b1;
			else if (do_pop && !do_push)
				fill <= fill - 1'b1;
		end
	end

	// head entry is visible without a read latency
	assign f_if.pop_data = mem[rd_ptr];
	assign f_if.empty_n  = (fill != '0);
	assign f_if.fill     = fill;

	a_fill_bound: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		fill <= (LGFLEN+1)'(DEPTH));

endmodule

`default_nettype wire

/* src/uart_fifo_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one FIFO with its producer and consumer, strobe handshake without back-pressure
interface uart_fifo_if #(
	parameter int LGFLEN = 2
);
	import uart_axil_pkg::*;

	// write side, a push into a full FIFO is dropped
	logic              push;
	uart_byte_t        push_data;
	// read side, pop_data always shows the head entry
	logic              pop;
	uart_byte_t        pop_data;
	logic              empty_n;
	// one bit wider than the pointers so that a full FIFO can be told apart
	logic [LGFLEN:0]   fill;

	modport producer (output push, output push_data, input empty_n, input fill);

	modport consumer (output pop, input pop_data, input empty_n, input fill);

	modport fifo (input push, input push_data, input pop,
		output pop_data, output empty_n, output fill);

endinterface

`default_nettype wire

/* src/uart_axil_pkg.sv */
`default_nettype none

package uart_axil_pkg;

	////////////////////
	// bus widths
	////////////////////

	// one word of the register port
	typedef logic [31:0] axil_data_t;

	// byte address covering the four word registers
	typedef logic [3:0] axil_addr_t;

	// word index taken from address bits 3:2
	typedef logic [1:0] reg_sel_t;

	localparam reg_sel_t REG_SETUP = 2'd0;
	localparam reg_sel_t REG_FIFO  = 2'd1;
	localparam reg_sel_t REG_RX    = 2'd2;
	localparam reg_sel_t REG_TX    = 2'd3;

	// every write and read completes with an OKAY response
	localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

	////////////////////
	// serial side
	////////////////////

	typedef logic [7:0] uart_byte_t;

	// number of S_AXI_ACLK cycles in one bit period
	typedef logic [23:0] baud_div_t;

	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

endpackage

`default_nettype wire
